// File: src.f
+incdir+hdl
hdl/databuf_pkg.sv
hdl/sample_ram.sv
hdl/cmd_timestamp.sv
hdl/feedback_sampler.sv
hdl/data_buffer.sv
hdl/databuf_top.sv
tb/tb_databuf.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the capture buffer testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_databuf -o sim_databuf

./obj_dir/sim_databuf | tee "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: tb/tb_databuf.sv
// ----------------------------------------------------------------------
// random test of the capture buffer against a cycle model of its rules
// inputs change on the falling edge, outputs are sampled there too
// buffer words are only compared once the model has written them
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "databuf_settings.svh"

module tb_databuf;
    import databuf_pkg::*;

    localparam int DEPTH       = 1 << `DATABUF_DEPTH_LOG2;
    localparam int SESSIONS    = 6;         // random capture sessions
    localparam int OPS         = 300;       // one or two cycles each
    localparam int WRAP_FRAMES = 1100;      // more entries than DEPTH
    localparam int QUIET       = 16400;     // past the 14 bit stamp range
    localparam int SESSION_CYC = 2 * OPS + 2 * (DEPTH + 8) + 64;  // ops, readback, slack
    localparam int CYCLE_LIMIT = (SESSIONS + 1) * SESSION_CYC + 2 * WRAP_FRAMES
                                 + QUIET + 2000;

    logic        clk;
    logic        arst_n;
    reg_wr_s     reg_wr;
    reg_rd_req_s reg_rd_req;
    reg_rd_rsp_s reg_rd_rsp;
    adc_frame_s  adc_frame;
    logic [15:0] databuf_status;

    int          errors   = 0;
    int          n_checks = 0;
    int          cycles   = 0;
    logic [31:0] lfsr     = 32'h1f8b_87d2;

    // reference model state, reset values
    logic      m_col   = 1'b0;
    chan_t     m_chan  = 4'd1;
    buf_addr_t m_idx   = '0;
    ts_t       m_ts    = '0;
    logic      m_we    = 1'b0;      // entry staged for next cycle
    logic      m_is_fb = 1'b0;
    cur_t      m_val   = '0;
    logic      m_fbw   = 1'b0;      // feedback strobe
    logic      m_fbl   = 1'b0;      // strobe one cycle back
    cur_t      m_fbcur = '0;
    logic      m_pend  = 1'b0;
    log_word_s exp_mem [DEPTH];
    bit        exp_vld [DEPTH];

    databuf_top UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .reg_wr         (reg_wr),
        .reg_rd_req     (reg_rd_req),
        .reg_rd_rsp     (reg_rd_rsp),
        .adc_frame      (adc_frame),
        .databuf_status (databuf_status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [15:0] model_status();
        return {m_col, 1'b0, m_chan, m_idx};
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED @%0t: %s", $time, msg);
    endtask

    // all drive tasks start and end just after a falling edge
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr.waddr = addr;
        reg_wr.wdata = data;
        reg_wr.wen   = 1'b1;            // single cycle strobe
        @(negedge clk);
        reg_wr.wen   = 1'b0;
    endtask

    task automatic cmd_write(input chan_t c, input logic collect, input cur_t v);
        reg_write({`ADDR_MAIN, 4'h0, c, `OFF_CMD_CUR}, {1'b0, collect, 14'd0, v});
    endtask

    task automatic adc_pulse();
        adc_frame.cur   = rand_bits(16 * `NUM_CHAN);
        adc_frame.valid = 1'b1;
        @(negedge clk);
        adc_frame.valid = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_rd_rsp_s rsp);
        reg_rd_req.raddr = addr;
        repeat (2) @(negedge clk);      // held two cycles, sample in second
        rsp = reg_rd_rsp;
    endtask

    task automatic check_word(input int i, output log_word_s w);
        reg_rd_rsp_s rsp;
        bus_read({`ADDR_DATABUF, 2'b00, buf_addr_t'(i)}, rsp);
        w = log_word_s'(rsp.rdata);
        n_checks++;
        assert (rsp.rwait && rsp.rdata == reg_data_t'(exp_mem[i]))
        else report_error($sformatf("word %0d read %h rwait %b, expected %h",
                                    i, rsp.rdata, rsp.rwait, exp_mem[i]));
    endtask

    task automatic check_buffer();
        log_word_s w;
        for (int i = 0; i < DEPTH; i++) begin
            if (exp_vld[i]) begin
                check_word(i, w);
            end
        end
    endtask

    // status register and unmapped offsets
    task automatic check_decode();
        reg_rd_rsp_s rsp;
        reg_addr_t   addr;
        bus_read({`ADDR_DATABUF, `OFF_DB_STATUS}, rsp);
        n_checks++;
        assert (!rsp.rwait && rsp.rdata == {16'd0, model_status()})
        else report_error($sformatf("status read %h rwait %b", rsp.rdata, rsp.rwait));
        for (int k = 0; k < 4; k++) begin
            addr = reg_addr_t'(rand_bits(16));
            if (addr[15:12] == `ADDR_DATABUF) begin
                addr[11] = 1'b1;                        // keep off the memory
            end
            if (addr[11:0] == `OFF_DB_STATUS) begin
                addr[0] = 1'b1;
            end
            bus_read(addr, rsp);
            n_checks++;
            assert (!rsp.rwait && rsp.rdata == '0)
            else report_error($sformatf("unmapped %h read %h rwait %b",
                                        addr, rsp.rdata, rsp.rwait));
        end
    endtask

    task automatic start_capture(input chan_t c);
        cur_t        v;
        reg_rd_rsp_s rsp;
        log_word_s   w;
        v = cur_t'(rand_bits(16));
        cmd_write(c, 1'b1, v);
        n_checks++;
        assert (databuf_status == {1'b1, 1'b0, c, 10'd0})
        else report_error($sformatf("start on %0d gave status %h", c, databuf_status));
        @(negedge clk);                 // first entry lands here
        bus_read({`ADDR_DATABUF, 12'h000}, rsp);
        w = log_word_s'(rsp.rdata);
        n_checks++;
        assert (rsp.rwait && !w.is_fb && !w.ts_over14 && w.ts_low == '0 && w.value == v)
        else report_error($sformatf("start entry %h, expected value %h", rsp.rdata, v));
    endtask

    task automatic random_ops(input int n, input chan_t cap);
        logic [3:0] op;
        chan_t      other;
        logic       last_adc;
        last_adc = 1'b0;
        for (int k = 0; k < n; k++) begin
            op = 4'(rand_bits(4));
            if (op < 4'd5) begin
                if (last_adc) begin
                    @(negedge clk);         // valid stays a one cycle pulse
                end
                adc_pulse();
            end else if (op < 4'd7) begin
                cmd_write(cap, 1'b1, cur_t'(rand_bits(16)));   // logs, keeps going
            end else if (op == 4'd7) begin
                other = chan_t'(rand_bits(4));
                if (other == cap) begin
                    other = other + 4'd1;
                end
                cmd_write(other, 1'(rand_bits(1)), cur_t'(rand_bits(16)));
            end else if (op == 4'd8) begin
                reg_write({`ADDR_MAIN, 4'h0, cap, 4'h2}, reg_data_t'(rand_bits(32)));
            end else begin
                @(negedge clk);
            end
            last_adc = (op < 4'd5);
        end
    endtask

    // ------------------------------------------------------------------
    // reference model, one step per rising edge
    // ------------------------------------------------------------------
    always @(posedge clk) begin : ref_model
        logic  cmd;
        chan_t wc;
        logic  start;
        logic  own;
        logic  stop;
        logic  trig;
        logic  logit;
        logic  take;
        cur_t  sample;
        if (arst_n) begin
            take   = adc_frame.valid && m_chan != 4'd0 && m_chan <= `NUM_CHAN;
            sample = take ? adc_frame.cur[int'(m_chan) - 1] : m_fbcur;
            cmd    = reg_wr.wen && reg_wr.waddr[15:12] == `ADDR_MAIN
                     && reg_wr.waddr[3:0] == `OFF_CMD_CUR;
            wc     = reg_wr.waddr[7:4];
            start  = cmd && !m_col && reg_wr.wdata[30] && wc != 4'd0 && wc <= `NUM_CHAN;
            own    = cmd && m_col && wc == m_chan;
            stop   = own && !reg_wr.wdata[30];
            trig   = m_fbw && !m_fbl;                  // strobe edge
            logit  = (m_col && trig) || m_pend;
            if (m_we) begin                             // stamp of the write cycle
                exp_mem[m_idx] = log_word_s'({m_is_fb, |m_ts[31:14], m_ts[13:0], m_val});
                exp_vld[m_idx] = 1'b1;
            end
            m_we = start || own || logit;
            if (start) begin
                m_col   = 1'b1;
                m_chan  = wc;
                m_idx   = '0;
                m_is_fb = 1'b0;
                m_val   = reg_wr.wdata[15:0];
            end else if (own) begin
                m_col   = reg_wr.wdata[30];
                m_idx   = m_idx + 1'b1;
                m_is_fb = 1'b0;
                m_val   = reg_wr.wdata[15:0];
                if (stop) begin
                    m_pend = 1'b0;
                end else if (trig) begin
                    m_pend = 1'b1;                      // feedback next cycle
                end
            end else if (logit) begin
                m_idx   = m_idx + 1'b1;
                m_is_fb = 1'b1;
                m_val   = m_fbcur;
                m_pend  = 1'b0;
            end
            m_ts    = cmd ? '0 : ((&m_ts) ? m_ts : m_ts + 1);
            m_fbl   = m_fbw;
            m_fbw   = take;
            m_fbcur = sample;
        end
    end

    // status output against the model, every cycle
    always @(negedge clk) begin
        if (arst_n) begin
            n_checks++;
            assert (databuf_status == model_status())
            else report_error($sformatf("status %h, expected %h",
                                        databuf_status, model_status()));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no end of test after %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d  errors: %0d", n_checks, errors);
            $display("Test failures found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin : stimulus
        chan_t     cap;
        log_word_s w;
        buf_addr_t idx;
        arst_n           = 1'b0;
        reg_wr           = '0;
        reg_rd_req       = '0;
        adc_frame        = '0;
        repeat (8) @(negedge clk);
        arst_n           = 1'b1;
        repeat (2) @(negedge clk);

        // random sessions with a stop and a full readback each
        for (int s = 0; s < SESSIONS; s++) begin
            cap = chan_t'(rand_bits(2)) + 4'd1;
            start_capture(cap);
            random_ops(OPS, cap);
            cmd_write(cap, 1'b0, cur_t'(rand_bits(16)));     // last entry
            repeat (10) begin
                adc_pulse();                                // idle, must not log
                @(negedge clk);
            end
            repeat (4) @(negedge clk);
            check_buffer();
            check_decode();
        end

        // wrap of the write index
        cap = chan_t'(rand_bits(2)) + 4'd1;
        start_capture(cap);
        repeat (WRAP_FRAMES) begin
            adc_pulse();
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        n_checks++;
        assert (databuf_status[15] && databuf_status[9:0] == buf_addr_t'(WRAP_FRAMES % DEPTH))
        else report_error($sformatf("after wrap status %h", databuf_status));

        // long quiet gap then one feedback entry
        repeat (QUIET) @(negedge clk);
        adc_pulse();
        repeat (4) @(negedge clk);
        idx = m_idx;
        check_word(int'(idx), w);
        n_checks++;
        assert (w.is_fb && w.ts_over14)
        else report_error($sformatf("entry %0d after quiet gap is %h", idx, w));
        cmd_write(cap, 1'b0, cur_t'(rand_bits(16)));
        repeat (4) @(negedge clk);
        check_buffer();
        check_decode();

        $display("checks: %0d  errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: hdl/databuf_top.sv
// ----------------------------------------------------------------------
// sample capture subsystem on the register bus
// ADC frames arrive already converted and the host never stalls
// a logged ADC frame is in memory two cycles after its valid
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module databuf_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  databuf_pkg::reg_wr_s     reg_wr,
    input  databuf_pkg::reg_rd_req_s reg_rd_req,
    output databuf_pkg::reg_rd_rsp_s reg_rd_rsp,
    input  databuf_pkg::adc_frame_s  adc_frame,
    output logic [15:0]              databuf_status
);
    import databuf_pkg::*;

    chan_t chan;        // captured channel
    logic  fb_wen;
    cur_t  fb_cur;
    logic  cmd_wr;      // decoded command write
    ts_t   ts;

    // feedback pick from the ADC frame
    feedback_sampler u_fb (
        .clk       (clk),
        .arst_n    (arst_n),
        .adc_frame (adc_frame),
        .chan      (chan),
        .fb_wen    (fb_wen),
        .fb_cur    (fb_cur)
    );

    // time since last command
    cmd_timestamp u_ts (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd_wr (cmd_wr),
        .ts     (ts)
    );

    data_buffer u_db (
        .clk        (clk),
        .arst_n     (arst_n),
        .reg_wr     (reg_wr),
        .reg_rd_req (reg_rd_req),
        .reg_rd_rsp (reg_rd_rsp),
        .fb_wen     (fb_wen),
        .fb_cur     (fb_cur),
        .ts         (ts),
        .chan       (chan),
        .cmd_wr     (cmd_wr),
        .status     (databuf_status)
    );

endmodule

// File: hdl/data_buffer.sv
// ----------------------------------------------------------------------
// capture controller for the motor current log
// start with a command write carrying bit 30 and stop with bit 30 clear
// while capturing, writes to other channels are ignored
// a feedback edge that meets a command write waits one cycle as pending
// memory reads need the address held two cycles (rwait high)
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "databuf_settings.svh"

module data_buffer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  databuf_pkg::reg_wr_s     reg_wr,
    input  databuf_pkg::reg_rd_req_s reg_rd_req,
    output databuf_pkg::reg_rd_rsp_s reg_rd_rsp,
    input  logic                     fb_wen,
    input  databuf_pkg::cur_t        fb_cur,
    input  databuf_pkg::ts_t         ts,
    output databuf_pkg::chan_t       chan,
    output logic                     cmd_wr,
    output logic [15:0]              status
);
    import databuf_pkg::*;

    // control state
    logic      collecting;
    buf_addr_t wr_idx;          // index of last entry written
    logic      buf_we;          // entry staged, written this cycle
    logic      fb_wen_last;
    logic      fb_pend;         // feedback entry deferred by a command

    // staged entry payload
    logic      ent_is_fb;
    cur_t      ent_value;

    log_word_s buf_wdata;
    log_word_s mem_rdata;

    // decode
    chan_t     wr_chan;
    logic      collect_bit;
    logic      chan_valid;
    logic      start_wr;
    logic      own_wr;
    logic      stop_wr;
    logic      fb_trig;
    logic      fb_log;
    logic      db_sel;

    // ------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------
    assign cmd_wr = reg_wr.wen
                    && (reg_wr.waddr[15:12] == `ADDR_MAIN)
                    && (reg_wr.waddr[3:0] == `OFF_CMD_CUR);

    assign wr_chan     = reg_wr.waddr[7:4];
    assign collect_bit = reg_wr.wdata[30];
    assign chan_valid  = (wr_chan != '0) && (wr_chan <= chan_t'(`NUM_CHAN));

    assign start_wr = cmd_wr && !collecting && collect_bit && chan_valid;
    assign own_wr   = cmd_wr && collecting && (wr_chan == chan);
    assign stop_wr  = own_wr && !collect_bit;  // logged, then idle

    assign fb_trig = fb_wen && !fb_wen_last;    // rising edge
    assign fb_log  = (collecting && fb_trig) || fb_pend;

    // ------------------------------------------------------------------
    // capture control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            collecting  <= 1'b0;
            chan        <= 4'd1;
            wr_idx      <= '0;
            buf_we      <= 1'b0;
            fb_wen_last <= 1'b0;
            fb_pend     <= 1'b0;
        end else begin
            fb_wen_last <= fb_wen;
            if (start_wr) begin
                collecting <= 1'b1;
                chan       <= wr_chan;
                wr_idx     <= '0;           // first entry at 0
                buf_we     <= 1'b1;
            end else if (own_wr) begin
                collecting <= collect_bit;
                wr_idx     <= wr_idx + 1'b1;
                buf_we     <= 1'b1;
                if (stop_wr) begin
                    fb_pend <= 1'b0;        // nothing logs after stop
                end else if (fb_trig) begin
                    fb_pend <= 1'b1;        // command wins this cycle
                end
            end else if (fb_log) begin
                wr_idx  <= wr_idx + 1'b1;   // wraps mod depth
                buf_we  <= 1'b1;
                fb_pend <= 1'b0;
            end else begin
                buf_we <= 1'b0;
            end
        end
    end

    // entry payload, follows the branch priority above
    always_ff @(posedge clk) begin
        if (start_wr || own_wr) begin
            ent_is_fb <= 1'b0;
            ent_value <= reg_wr.wdata[15:0];
        end else if (fb_log) begin
            ent_is_fb <= 1'b1;
            ent_value <= fb_cur;            // held by sampler
        end
    end

    // time stamp taken in the write cycle
    // so a command entry always sees the restarted count
    assign buf_wdata.is_fb     = ent_is_fb;
    assign buf_wdata.ts_over14 = |ts[31:14];
    assign buf_wdata.ts_low    = ts[13:0];
    assign buf_wdata.value     = ent_value;

    sample_ram u_ram (
        .clk   (clk),
        .we    (buf_we),
        .waddr (wr_idx),
        .wdata (buf_wdata),
        .raddr (reg_rd_req.raddr[`DATABUF_DEPTH_LOG2-1:0]),
        .rdata (mem_rdata)
    );

    // ------------------------------------------------------------------
    // status and read decode
    // ------------------------------------------------------------------
    assign status = {collecting, 1'b0, chan, wr_idx};

    assign db_sel = (reg_rd_req.raddr[15:12] == `ADDR_DATABUF);

    always_comb begin
        reg_rd_rsp = '0;                            // unmapped reads 0
        if (db_sel && !reg_rd_req.raddr[11]) begin
            reg_rd_rsp.rdata = reg_data_t'(mem_rdata);  // last cycle's addr
            reg_rd_rsp.rwait = 1'b1;
        end else if (db_sel && (reg_rd_req.raddr[11:0] == `OFF_DB_STATUS)) begin
            reg_rd_rsp.rdata = {16'd0, status};
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // idle write only for the entry of a stop write
    a_we_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        buf_we && !collecting |-> $past(stop_wr)
    );

    // captured channel is frozen during capture
    a_chan_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        collecting |=> $stable(chan)
    );

endmodule

// File: hdl/feedback_sampler.sv
// ----------------------------------------------------------------------
// picks the captured channel's current out of each ADC frame
// fb_wen follows frame valid by one cycle and fb_cur holds till next frame
// a channel outside 1..NUM_CHAN gives no strobe
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "databuf_settings.svh"

module feedback_sampler (
    input  logic                    clk,
    input  logic                    arst_n,
    input  databuf_pkg::adc_frame_s adc_frame,
    input  databuf_pkg::chan_t      chan,       // from capture controller
    output logic                    fb_wen,
    output databuf_pkg::cur_t       fb_cur
);
    import databuf_pkg::*;

    localparam int SEL_W = (`NUM_CHAN > 1) ? $clog2(`NUM_CHAN) : 1;

    logic             chan_ok;
    logic [SEL_W-1:0] sel;          // frame slot of chan
    cur_t             sel_cur;
    logic             take;

    // channel check and slot select
    assign chan_ok = (chan != '0) && (chan <= chan_t'(`NUM_CHAN));
    assign sel     = SEL_W'(chan - 4'd1);    // channel c sits at c-1
    assign sel_cur = adc_frame.cur[sel];
    assign take    = adc_frame.valid && chan_ok;

    // ------------------------------------------------------------------
    // strobe
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fb_wen <= 1'b0;
        end else begin
            fb_wen <= take;             // one cycle per frame
        end
    end

    // sample register
    // only loads on a usable frame so value stays put for the buffer
    always_ff @(posedge clk) begin
        if (take) begin
            fb_cur <= sel_cur;
        end
    end

endmodule

// File: hdl/cmd_timestamp.sv
// ----------------------------------------------------------------------
// cycle counter restarted by every command current write
// reads 0 in the cycle after the write and saturates at all ones
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cmd_timestamp (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cmd_wr,    // decoded command write pulse
    output databuf_pkg::ts_t ts
);
    import databuf_pkg::*;

    localparam ts_t TS_MAX = '1;

    // ------------------------------------------------------------------
    // counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ts <= '0;
        end else if (cmd_wr) begin
            ts <= '0;                   // restart on each command
        end else if (ts != TS_MAX) begin
            ts <= ts + 1'b1;
        end
        // at TS_MAX just hold
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    // only a command write may pull the count back
    a_ts_no_decrease: assert property (
        @(posedge clk) disable iff (!arst_n)
        !cmd_wr |=> ts >= $past(ts)
    );

endmodule

// File: hdl/sample_ram.sv
// ----------------------------------------------------------------------
// log memory with one write port and one read port on the same clock
// read data is registered and shows the old word on a same address write
// contents are undefined after power up and are not reset
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "databuf_settings.svh"

module sample_ram (
    input  logic                   clk,
    input  logic                   we,
    input  databuf_pkg::buf_addr_t waddr,
    input  databuf_pkg::log_word_s wdata,
    input  databuf_pkg::buf_addr_t raddr,
    output databuf_pkg::log_word_s rdata
);
    import databuf_pkg::*;

    localparam int DEPTH = 1 << `DATABUF_DEPTH_LOG2;

    log_word_s mem [DEPTH];     // maps to block RAM

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port
    // one cycle latency, the host bus covers it with rwait
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: hdl/databuf_pkg.sv
// ----------------------------------------------------------------------
// shared types of the capture buffer
// widths of the buffer index and the ADC frame follow the settings
// log_word_s must stay exactly 32 bits to fit the register data bus
// ----------------------------------------------------------------------
`include "databuf_settings.svh"

package databuf_pkg;

    // plain vectors with a meaning
    typedef logic [15:0]                    reg_addr_t;
    typedef logic [31:0]                    reg_data_t;
    typedef logic [3:0]                     chan_t;     // 1..NUM_CHAN
    typedef logic [15:0]                    cur_t;      // signed current, raw bits
    typedef logic [31:0]                    ts_t;       // cycles since last command
    typedef logic [`DATABUF_DEPTH_LOG2-1:0] buf_addr_t;

    // register write bus, no acknowledge
    typedef struct packed {
        reg_addr_t waddr;
        reg_data_t wdata;
        logic      wen;         // single cycle strobe
    } reg_wr_s;

    typedef struct packed {
        reg_addr_t raddr;
    } reg_rd_req_s;

    typedef struct packed {
        reg_data_t rdata;
        logic      rwait;       // data valid one cycle later
    } reg_rd_rsp_s;

    // one ADC conversion result for all channels
    typedef struct packed {
        cur_t [`NUM_CHAN-1:0] cur;      // channel c at index c-1
        logic                 valid;    // one cycle pulse
    } adc_frame_s;

    // one buffer entry
    typedef struct packed {
        logic        is_fb;     // 1 feedback, 0 command
        logic        ts_over14; // time stamp beyond 14 bits
        logic [13:0] ts_low;
        cur_t        value;
    } log_word_s;

endpackage

// File: hdl/databuf_settings.svh
// ----------------------------------------------------------------------
// register map and buffer geometry of the sample capture buffer
// channel numbers run from 1 to NUM_CHAN and 0 is never captured
// buffer depth must be a power of two since the write index wraps
// ----------------------------------------------------------------------
`ifndef DATABUF_SETTINGS_SVH
`define DATABUF_SETTINGS_SVH

// block select in addr[15:12]
`define ADDR_MAIN           4'h0        // main register block
`define ADDR_DATABUF        4'h7        // buffer read block

// offsets inside a block
`define OFF_CMD_CUR         4'h1        // command current in addr[3:0]
`define OFF_DB_STATUS       12'h800     // buffer status in addr[11:0]

// buffer geometry
`define DATABUF_DEPTH_LOG2  10          // 1024 log words

// motor channels served by the ADC frame
`define NUM_CHAN            4

`endif
